/* verilog/memTypes.sv */
package memTypes;

    // Word address inside one cache bank
    typedef logic [9:0] sramAddr_t;

    // Word address on the external RAM side
    typedef logic [29:0] extAddr_t;

    // Data word on the bus and in the banks
    typedef logic [31:0] word_t;

    // Byte write mask, bit set means the byte is written
    typedef logic [3:0] wmask_t;

    // Words moved so far in a fill
    typedef logic [9:0] progress_t;

endpackage

/* verilog/memCtrlTypes.sv */
package memCtrlTypes;

    typedef enum logic [1:0] {
        Idle,
        WaitExt,
        WriteExt,
        ReadExt
    } mcState_t;

    typedef logic [2:0] waitCnt_t;

    // Command word on the external bus
    localparam int CMD_WRITE_BIT = 31;
    localparam int CMD_ADDR_BITS = 30;

    // External RAM latency before the first fill word
    localparam waitCnt_t READ_WAIT = 3'd5;

    // Address reg, SRAM read and staging reg ahead of the bus
    localparam int WRITE_PIPE = 3;

endpackage

/* verilog/CacheSram.sv */
`timescale 1ns/1ps

module CacheSram
    import memTypes::*;
(
    input  logic      clk,

    // Port select, high hands the bank to the controller
    input  logic      used,

    input  logic      coreCe,
    input  logic      coreWe,
    input  wmask_t    coreWm,
    input  sramAddr_t coreAddr,
    input  word_t     coreWdata,

    input  logic      ctrlCe,
    input  logic      ctrlWe,
    input  sramAddr_t ctrlAddr,
    input  word_t     ctrlWdata,

    output word_t     rdata
);

    localparam int DEPTH = 2 ** $bits(sramAddr_t);

    word_t mem [DEPTH];

    logic      selCe;
    logic      selWe;
    wmask_t    selWm;
    sramAddr_t selAddr;
    word_t     selWdata;

    always_comb begin
        if (used) begin
            selCe    = ctrlCe;
            selWe    = ctrlWe;
            // Controller always writes whole words
            selWm    = '1;
            selAddr  = ctrlAddr;
            selWdata = ctrlWdata;
        end else begin
            selCe    = coreCe;
            selWe    = coreWe;
            selWm    = coreWm;
            selAddr  = coreAddr;
            selWdata = coreWdata;
        end
    end

    // Enables are active low
    always_ff @(posedge clk) begin
        if (!selCe) begin
            if (!selWe) begin
                for (int b = 0; b < $bits(wmask_t); b++) begin
                    if (selWm[b]) begin
                        mem[selAddr][8*b +: 8] <= selWdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[selAddr];
            end
        end
    end

    weImpliesCe: assert property (@(posedge clk) !selWe |-> !selCe)
        else $error("CacheSram write enable without chip enable");

endmodule

/* verilog/MemoryController.sv */
`timescale 1ns/1ps

module MemoryController
    import memTypes::*;
    import memCtrlTypes::*;
#(
    parameter int NUM_CACHES  = 2,
    parameter int ILINE_WORDS = 64,
    parameter int DLINE_WORDS = 128
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          ce,
    input  logic                          we,
    input  logic [$clog2(NUM_CACHES)-1:0] cacheId,
    input  sramAddr_t                     sramAddr,
    input  extAddr_t                      extAddr,
    output logic                          busy,
    output progress_t                     progress,

    output logic [NUM_CACHES-1:0]         used,
    output logic [NUM_CACHES-1:0]         bankCe,
    output logic [NUM_CACHES-1:0]         bankWe,
    output sramAddr_t                     bankAddr [NUM_CACHES],
    output word_t                         bankWdata [NUM_CACHES],
    input  word_t                         bankRdata [NUM_CACHES],

    output logic                          extEn,
    output logic                          extOen,
    output word_t                         extBusOut,
    input  word_t                         extBusIn
);

    mcState_t state;
    logic     isWrite;
    waitCnt_t waitCnt;

    logic [$clog2(NUM_CACHES)-1:0] curId;
    sramAddr_t baseAddr;
    progress_t cnt;
    progress_t len;

    sramAddr_t addrReg;
    word_t     wdataReg;
    word_t     stage;
    word_t     cmdWord;

    // Bit 30 of the command stays zero
    always_comb begin
        cmdWord = '0;
        cmdWord[CMD_WRITE_BIT] = we;
        cmdWord[CMD_ADDR_BITS-1:0] = extAddr;
    end

    // Only the bank with its enable low acts on these
    always_comb begin
        for (int k = 0; k < NUM_CACHES; k++) begin
            bankAddr[k]  = addrReg;
            bankWdata[k] = wdataReg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= Idle;
            busy     <= 1'b0;
            progress <= '0;
            used     <= '0;
            bankCe   <= '1;
            bankWe   <= '1;
            extEn    <= 1'b0;
            extOen   <= 1'b1;
            curId    <= '0;
        end else begin
            case (state)
                Idle: begin
                    extOen <= 1'b1;
                    if (ce) begin
                        state    <= WaitExt;
                        isWrite  <= we;
                        waitCnt  <= we ? '0 : READ_WAIT;
                        curId    <= cacheId;
                        baseAddr <= sramAddr;
                        cnt      <= '0;
                        // Bank 0 holds instruction lines
                        len      <= (cacheId == '0) ? progress_t'(ILINE_WORDS)
                                                    : progress_t'(DLINE_WORDS);
                        extEn     <= 1'b1;
                        extBusOut <= cmdWord;
                        busy      <= 1'b1;
                        progress  <= '0;
                    end
                end

                WaitExt: begin
                    if (waitCnt == '0) begin
                        used[curId] <= 1'b1;
                        if (isWrite) begin
                            state <= WriteExt;
                        end else begin
                            state  <= ReadExt;
                            extOen <= 1'b0;
                        end
                    end
                    waitCnt <= waitCnt - 1'b1;
                end

                WriteExt: begin
                    cnt   <= cnt + 1'b1;
                    stage <= bankRdata[curId];
                    if (cnt < len) begin
                        bankCe[curId] <= 1'b0;
                        bankWe[curId] <= 1'b1;
                        addrReg       <= baseAddr + sramAddr_t'(cnt);
                    end else begin
                        // Reads issued, hand the bank back
                        bankCe[curId] <= 1'b1;
                        used[curId]   <= 1'b0;
                    end

                    if (cnt == len + progress_t'(WRITE_PIPE)) begin
                        extEn <= 1'b0;
                        busy  <= 1'b0;
                        state <= Idle;
                    end else if (cnt >= progress_t'(WRITE_PIPE)) begin
                        extBusOut <= stage;
                    end
                end

                ReadExt: begin
                    cnt <= cnt + 1'b1;
                    if (cnt < len) begin
                        bankCe[curId] <= 1'b0;
                        bankWe[curId] <= 1'b0;
                        addrReg       <= baseAddr + sramAddr_t'(cnt);
                        wdataReg      <= extBusIn;
                        progress      <= progress + 1'b1;
                    end else begin
                        bankCe[curId] <= 1'b1;
                        bankWe[curId] <= 1'b1;
                        used[curId]   <= 1'b0;
                        busy          <= 1'b0;
                        progress      <= '0;
                        extEn         <= 1'b0;
                        state         <= Idle;
                    end
                end

                default: state <= Idle;
            endcase
        end
    end

    usedOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(used))
        else $error("More than one bank owned by the controller");

    usedWhileBusy: assert property (@(posedge clk) disable iff (rst) |used |-> busy)
        else $error("Bank owned while controller not busy");

    // Output enable lingers one cycle past the fill
    oenInRead: assert property (@(posedge clk) disable iff (rst)
        !extOen |-> (state == ReadExt) || ($past(state) == ReadExt))
        else $error("RAM output enabled outside a fill");

endmodule

/* verilog/MemorySubsystem.sv */
`timescale 1ns/1ps

module MemorySubsystem
    import memTypes::*;
#(
    parameter int NUM_CACHES  = 2,
    parameter int ILINE_WORDS = 64,
    parameter int DLINE_WORDS = 128
) (
    input  logic                          clk,
    input  logic                          rst,

    // Transfer requests
    input  logic                          ce,
    input  logic                          we,
    input  logic [$clog2(NUM_CACHES)-1:0] cacheId,
    input  sramAddr_t                     sramAddr,
    input  extAddr_t                      extAddr,
    output logic                          busy,
    output progress_t                     progress,

    // Core side of the banks
    input  logic [NUM_CACHES-1:0]         coreCe,
    input  logic [NUM_CACHES-1:0]         coreWe,
    input  wmask_t                        coreWm [NUM_CACHES],
    input  sramAddr_t                     coreAddr [NUM_CACHES],
    input  word_t                         coreWdata [NUM_CACHES],
    output word_t                         coreRdata [NUM_CACHES],
    output logic [NUM_CACHES-1:0]         used,

    // External RAM bus
    output logic                          extEn,
    output logic                          extOen,
    output word_t                         extBusOut,
    input  word_t                         extBusIn
);

    logic [NUM_CACHES-1:0] bankCe;
    logic [NUM_CACHES-1:0] bankWe;
    sramAddr_t             bankAddr [NUM_CACHES];
    word_t                 bankWdata [NUM_CACHES];

    MemoryController #(
        .NUM_CACHES (NUM_CACHES),
        .ILINE_WORDS(ILINE_WORDS),
        .DLINE_WORDS(DLINE_WORDS)
    ) u_MemoryController (
        .clk      (clk),
        .rst      (rst),
        .ce       (ce),
        .we       (we),
        .cacheId  (cacheId),
        .sramAddr (sramAddr),
        .extAddr  (extAddr),
        .busy     (busy),
        .progress (progress),
        .used     (used),
        .bankCe   (bankCe),
        .bankWe   (bankWe),
        .bankAddr (bankAddr),
        .bankWdata(bankWdata),
        .bankRdata(coreRdata),
        .extEn    (extEn),
        .extOen   (extOen),
        .extBusOut(extBusOut),
        .extBusIn (extBusIn)
    );

    // Read data feeds both the core and the controller
    for (genvar k = 0; k < NUM_CACHES; k++) begin : g_bank
        CacheSram u_CacheSram (
            .clk      (clk),
            .used     (used[k]),
            .coreCe   (coreCe[k]),
            .coreWe   (coreWe[k]),
            .coreWm   (coreWm[k]),
            .coreAddr (coreAddr[k]),
            .coreWdata(coreWdata[k]),
            .ctrlCe   (bankCe[k]),
            .ctrlWe   (bankWe[k]),
            .ctrlAddr (bankAddr[k]),
            .ctrlWdata(bankWdata[k]),
            .rdata    (coreRdata[k])
        );
    end

endmodule

/* bench/ExtRamModel.sv */
`timescale 1ns/1ps

module ExtRamModel
    import memTypes::*;
    import memCtrlTypes::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  extEn,
    input  logic  extOen,
    input  word_t extBusOut,
    output word_t extBusIn
);

    // Only written words are stored, the rest follow a fill pattern
    word_t mem [bit [29:0]];

    logic     prevEn;
    logic     isWr;
    extAddr_t base;
    int       rdIdx;
    int       bursts;
    int       badCmd;

    // Every bus sample after the command of a write burst
    word_t burst [$];

    function automatic word_t patternAt(extAddr_t a);
        return {a[13:0], a[29:12]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t peek(extAddr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return patternAt(a);
    endfunction

    function automatic int burstSize();
        return burst.size();
    endfunction

    // Block words sit in the last len samples of the burst
    function automatic word_t burstWord(int len, int i);
        return burst[burst.size() - len + i];
    endfunction

    task automatic commitWriteback(input int len);
        for (int i = 0; i < len; i++) begin
            mem[base + extAddr_t'(i)] = burstWord(len, i);
        end
    endtask

    always @(posedge clk) begin
        int nextIdx;
        if (rst) begin
            prevEn   <= 1'b0;
            isWr     <= 1'b0;
            base     <= '0;
            rdIdx    <= 0;
            bursts   <= 0;
            badCmd   <= 0;
            extBusIn <= '0;
            burst.delete();
        end else begin
            prevEn <= extEn;
            nextIdx = rdIdx;
            if (extEn && !prevEn) begin
                // First cycle of extEn carries the command word
                isWr  <= extBusOut[CMD_WRITE_BIT];
                base  <= extBusOut[CMD_ADDR_BITS-1:0];
                nextIdx = 0;
                if (extBusOut[30]) begin
                    badCmd <= badCmd + 1;
                end
                burst.delete();
            end else if (extEn && isWr) begin
                burst.push_back(extBusOut);
            end
            if (!extEn && prevEn) begin
                bursts <= bursts + 1;
            end
            // Word i is driven in the i-th cycle with extOen low
            if (!extOen) begin
                nextIdx = nextIdx + 1;
            end
            extBusIn <= peek(base + extAddr_t'(nextIdx));
            rdIdx    <= nextIdx;
        end
    end

endmodule

/* bench/MemorySubsystemTb.sv */
`timescale 1ns/1ps

module MemorySubsystemTb;
    import memTypes::*;

    localparam int NUM_CACHES  = 2;
    localparam int ILINE_WORDS = 64;
    localparam int DLINE_WORDS = 128;
    localparam int TIMEOUT     = 1000;

    logic      clk = 1'b0;
    logic      rst;
    logic      ce;
    logic      we;
    logic [0:0] cacheId;
    sramAddr_t sramAddr;
    extAddr_t  extAddr;
    logic      busy;
    progress_t progress;

    logic [NUM_CACHES-1:0] coreCe;
    logic [NUM_CACHES-1:0] coreWe;
    wmask_t    coreWm [NUM_CACHES];
    sramAddr_t coreAddr [NUM_CACHES];
    word_t     coreWdata [NUM_CACHES];
    word_t     coreRdata [NUM_CACHES];
    logic [NUM_CACHES-1:0] used;

    logic  extEn;
    logic  extOen;
    word_t extBusOut;
    word_t extBusIn;

    // Reference contents of the banks and of the written RAM words
    word_t bankShadow [NUM_CACHES][1024];
    word_t ramShadow [bit [29:0]];
    int    expBursts;

    always #2 clk = ~clk;

    MemorySubsystem #(
        .NUM_CACHES (NUM_CACHES),
        .ILINE_WORDS(ILINE_WORDS),
        .DLINE_WORDS(DLINE_WORDS)
    ) u_MemorySubsystem (
        .clk(clk), .rst(rst), .ce(ce), .we(we), .cacheId(cacheId),
        .sramAddr(sramAddr), .extAddr(extAddr), .busy(busy), .progress(progress),
        .coreCe(coreCe), .coreWe(coreWe), .coreWm(coreWm), .coreAddr(coreAddr),
        .coreWdata(coreWdata), .coreRdata(coreRdata), .used(used),
        .extEn(extEn), .extOen(extOen), .extBusOut(extBusOut), .extBusIn(extBusIn)
    );

    ExtRamModel ram (
        .clk(clk), .rst(rst), .extEn(extEn), .extOen(extOen),
        .extBusOut(extBusOut), .extBusIn(extBusIn)
    );

    function automatic int lenOf(int id);
        return (id == 0) ? ILINE_WORDS : DLINE_WORDS;
    endfunction

    // Unwritten RAM words hold an address-derived pattern
    function automatic word_t ramExpect(extAddr_t a);
        if (ramShadow.exists(a)) begin
            return ramShadow[a];
        end
        return {a[13:0], a[29:12]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t applyMask(word_t old, word_t data, wmask_t mask);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    // Blocked writes land on a bank that the controller owns
    task automatic coreWrite(input int k, input sramAddr_t a, input word_t d,
                             input wmask_t m, input bit blocked);
        @(posedge clk);
        coreCe[k]    <= 1'b0;
        coreWe[k]    <= 1'b0;
        coreAddr[k]  <= a;
        coreWdata[k] <= d;
        coreWm[k]    <= m;
        // used seen here is what the bank samples on the next edge
        @(negedge clk);
        checkEq(used[k], blocked, "bank ownership during core write");
        if (!blocked) begin
            bankShadow[k][a] = applyMask(bankShadow[k][a], d, m);
        end
        @(posedge clk);
        coreCe[k] <= 1'b1;
        coreWe[k] <= 1'b1;
    endtask

    task automatic coreRead(input int k, input sramAddr_t a, output word_t d);
        @(posedge clk);
        coreCe[k]   <= 1'b0;
        coreWe[k]   <= 1'b1;
        coreAddr[k] <= a;
        @(posedge clk);
        coreCe[k] <= 1'b1;
        @(negedge clk);
        d = coreRdata[k];
    endtask

    task automatic waitUsed(input int id);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!used[id]) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                failRun("timeout waiting for the controller to take the bank");
            end
            @(negedge clk);
        end
    endtask

    // mode 1 adds core writes during the transfer, mode 2 a second ce pulse
    task automatic runTransfer(input bit w, input int id, input sramAddr_t sa,
                               input extAddr_t ea, input int mode);
        int        len;
        int        cycles;
        progress_t last;
        len = lenOf(id);
        @(posedge clk);
        ce       <= 1'b1;
        we       <= w;
        cacheId  <= id[0:0];
        sramAddr <= sa;
        extAddr  <= ea;
        @(posedge clk);
        ce <= 1'b0;
        expBursts++;
        if (mode == 1) begin
            waitUsed(id);
            for (int j = 0; j < 4; j++) begin
                coreWrite(id, sramAddr_t'($urandom), $urandom, wmask_t'($urandom), 1'b1);
                coreWrite(1 - id, sramAddr_t'($urandom), $urandom, wmask_t'($urandom), 1'b0);
            end
        end else if (mode == 2) begin
            repeat (3) @(posedge clk);
            ce       <= 1'b1;
            we       <= ~w;
            cacheId  <= ~id[0:0];
            sramAddr <= sramAddr_t'($urandom);
            extAddr  <= extAddr_t'($urandom);
            @(posedge clk);
            ce <= 1'b0;
        end
        cycles = 0;
        last   = '0;
        @(negedge clk);
        while (busy) begin
            if (!w) begin
                if (progress > progress_t'(len)) begin
                    checkEq(progress, len, "progress above block length");
                end
                if (progress < last) begin
                    checkEq(progress, last, "progress decreased");
                end
                last = progress;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                failRun("timeout waiting for busy to fall");
            end
            @(negedge clk);
        end
        if (!w) begin
            checkEq(last, len, "final progress of fill");
            checkEq(progress, 0, "progress after fill");
        end
        cycles = 0;
        while (ram.bursts != expBursts) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                failRun("timeout waiting for the external RAM to see the end of the transfer");
            end
            @(negedge clk);
        end
        if (w) begin
            if (ram.burstSize() < len) begin
                failRun("external RAM received fewer writeback words than the block length");
            end
            for (int i = 0; i < len; i++) begin
                checkEq(ram.burstWord(len, i), bankShadow[id][sa + sramAddr_t'(i)],
                        "writeback word");
                ramShadow[ea + extAddr_t'(i)] = bankShadow[id][sa + sramAddr_t'(i)];
            end
            ram.commitWriteback(len);
        end else begin
            for (int i = 0; i < len; i++) begin
                bankShadow[id][sa + sramAddr_t'(i)] = ramExpect(ea + extAddr_t'(i));
            end
        end
    endtask

    task automatic checkBanks();
        word_t d;
        for (int k = 0; k < NUM_CACHES; k++) begin
            for (int a = 0; a < 1024; a++) begin
                coreRead(k, sramAddr_t'(a), d);
                checkEq(d, bankShadow[k][a], $sformatf("bank %0d word %0d", k, a));
            end
        end
    endtask

    task automatic checkRam();
        foreach (ramShadow[a]) begin
            checkEq(ram.peek(a), ramShadow[a], $sformatf("RAM word %h", a));
        end
        checkEq(ram.badCmd, 0, "command words with bit 30 set");
    endtask

    initial begin
        void'($urandom(32'h71be_b6fc));
        rst       = 1'b1;
        ce        = 1'b0;
        we        = 1'b0;
        cacheId   = '0;
        sramAddr  = '0;
        extAddr   = '0;
        coreCe    = '1;
        coreWe    = '1;
        expBursts = 0;
        for (int k = 0; k < NUM_CACHES; k++) begin
            coreWm[k]    = '0;
            coreAddr[k]  = '0;
            coreWdata[k] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Reset values
        @(negedge clk);
        checkEq(busy, 0, "busy after reset");
        checkEq(extEn, 0, "extEn after reset");
        checkEq(used, 0, "used after reset");
        checkEq(progress, 0, "progress after reset");
        checkEq(extOen, 1, "extOen after reset");

        // Known bank contents
        for (int k = 0; k < NUM_CACHES; k++) begin
            for (int a = 0; a < 1024; a++) begin
                coreWrite(k, sramAddr_t'(a), $urandom, 4'hf, 1'b0);
            end
        end

        runTransfer(1'b0, $urandom % 2, sramAddr_t'($urandom), extAddr_t'($urandom), 0);
        checkBanks();

        for (int j = 0; j < 20; j++) begin
            coreWrite(1, sramAddr_t'($urandom % 128), $urandom, wmask_t'($urandom), 1'b0);
        end
        runTransfer(1'b1, 1, '0, extAddr_t'($urandom), 0);
        runTransfer(1'b0, 1, sramAddr_t'($urandom), extAddr_t'($urandom), 1);
        checkBanks();

        runTransfer(1'b1, 0, sramAddr_t'($urandom), extAddr_t'($urandom), 2);
        checkBanks();
        checkRam();

        for (int j = 0; j < 12; j++) begin
            runTransfer(1'($urandom), $urandom % 2, sramAddr_t'($urandom),
                        extAddr_t'($urandom % 4096), 0);
            coreWrite($urandom % 2, sramAddr_t'($urandom), $urandom, wmask_t'($urandom), 1'b0);
        end
        checkBanks();
        checkRam();

        $display("all tests passed");
        $finish;
    end

endmodule

/* MemorySubsystem.f */
verilog/memTypes.sv
verilog/memCtrlTypes.sv
verilog/CacheSram.sv
verilog/MemoryController.sv
verilog/MemorySubsystem.sv
bench/ExtRamModel.sv
bench/MemorySubsystemTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module MemorySubsystemTb \
    -f MemorySubsystem.f -o simv

if ./obj_dir/simv | tee /dev/stderr | grep -x "all tests passed" > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
